// File: sources.f
source/tlk_pkg.sv
source/tlk_pattern_gen.sv
source/tlk_word_fifo.sv
source/tlk_tx_framer.sv
source/tlk_rx_checker.sv
source/tlk_link_top.sv
verification/tb_tlk_link.sv

// File: verification/tb_tlk_link.sv
`timescale 1ns/10ps

module tb_tlk_link;
    import tlk_pkg::*;

    localparam int FRAME_LEN  = 8;
    localparam int FIFO_DEPTH = 16;
    localparam int NUM_RUNS   = 5;  // four clean modes then one with injection
    localparam int MIN_RUN    = 40;
    localparam int MAX_RUN    = 120;
    localparam int WATCHDOG_CYCLES = 2 * NUM_RUNS * (MAX_RUN + 4 * FRAME_LEN + FIFO_DEPTH);
    localparam int ACK_LIMIT  = 8 * FRAME_LEN + 2 * FIFO_DEPTH;

    logic       sys_clk_50 = 1'b0;
    logic       sys_rstn, start, stop;
    logic       stop_ack, tkmsb, tklsb, enable;
    logic       rkmsb, rklsb;
    tlk_mode_t  mode;
    tlk_data_t  txd, rxd;
    tlk_count_t frame_count, err_count;

    logic       inj_on, inject_now, in_frame, stopped, enable_seen;
    tlk_data_t  inj_mask, exp_word;
    int         inj_pos;            // data word to corrupt
    int         data_idx, frame_no, eof_seen, inj_count, ack_count;
    int         mismatch_errs = 0;
    int         problem_errs  = 0;

    always #2 sys_clk_50 = ~sys_clk_50;

    // odd frames get one corrupted data word while injection is on
    assign inject_now = inj_on && frame_no[0] && in_frame && !tklsb && !tkmsb
                        && (data_idx == inj_pos);
    assign rxd   = txd ^ (inject_now ? inj_mask : 16'h0000);
    assign rkmsb = tkmsb;
    assign rklsb = tklsb;

    tlk_link_top #(.FRAME_LEN(FRAME_LEN), .FIFO_DEPTH(FIFO_DEPTH)) i_tlk_link_top (
        .i_sys_clk_50  (sys_clk_50),
        .i_sys_rstn    (sys_rstn),
        .i_start       (start),
        .i_stop        (stop),
        .i_mode        (mode),
        .o_stop_ack    (stop_ack),
        .o_txd         (txd),
        .o_tkmsb       (tkmsb),
        .o_tklsb       (tklsb),
        .o_enable      (enable),
        .i_rxd         (rxd),
        .i_rkmsb       (rkmsb),
        .i_rklsb       (rklsb),
        .o_frame_count (frame_count),
        .o_err_count   (err_count)
    );

    function automatic tlk_data_t start_word(input tlk_mode_t m);
        case (m)
            PAT_PRBS: return 16'hACE1;
            PAT_ALT:  return 16'h5555;
            PAT_WALK: return 16'h0001;
            default:  return 16'h0000;
        endcase
    endfunction

    function automatic tlk_data_t advance_word(input tlk_mode_t m, input tlk_data_t w);
        case (m)
            PAT_PRBS: return {w[14:0], ^(w & 16'hB400)};  // taps 16,14,13,11
            PAT_ALT:  return (w == 16'h5555) ? 16'hAAAA : 16'h5555;
            PAT_WALK: return (w == 16'h8000) ? 16'h0001 : (w << 1);
            default:  return w + 16'd1;
        endcase
    endfunction

    function automatic tlk_data_t new_mask();
        return tlk_data_t'($urandom % 65535) + 16'd1;   // never zero
    endfunction

    task automatic record_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        mismatch_errs++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error at %0t: %s", $time, msg);
        problem_errs++;
    endtask

    // stream monitor samples the word shown during the past cycle
    always @(posedge sys_clk_50) begin
        if (!sys_rstn) begin
            {in_frame, enable_seen} <= 2'b00;
            stopped   <= 1'b1;
            exp_word  <= '0;
            {data_idx, frame_no, eof_seen, inj_count, ack_count, inj_pos} <= '0;
            inj_mask  <= new_mask();
        end else begin
            if (tklsb && !tkmsb && txd[7:0] == K_SOF[7:0]) begin
                assert (!in_frame) else report_problem("start word inside an open frame");
                assert (txd[15:8] == {5'b00000, mode})
                    else record_mismatch($sformatf("start word %h, mode %0d", txd, mode));
                in_frame <= 1'b1;
                exp_word <= start_word(mode);
                data_idx <= 0;
                inj_pos  <= int'($urandom % FRAME_LEN);
            end else if (!tklsb && !tkmsb) begin
                assert (in_frame) else report_problem("data word outside a frame");
                assert (txd == exp_word && data_idx < FRAME_LEN) else record_mismatch(
                    $sformatf("data word %0d is %h, expected %h", data_idx, txd, exp_word));
                exp_word <= advance_word(mode, exp_word);
                data_idx <= data_idx + 1;
                if (inject_now) begin
                    inj_count <= inj_count + 1;
                    inj_mask  <= new_mask();
                end
            end else if (tklsb && tkmsb) begin
                assert (txd == K_EOF) else record_mismatch($sformatf("end word %h", txd));
                assert (in_frame) else report_problem("end word without a start word");
                assert (data_idx == FRAME_LEN)
                    else record_mismatch($sformatf("frame held %0d data words", data_idx));
                in_frame <= 1'b0;
                eof_seen <= eof_seen + 1;
                frame_no <= frame_no + 1;
            end else begin
                assert (tklsb && !tkmsb && txd == K_IDLE)
                    else record_mismatch($sformatf("bad control word %h", txd));
            end

            if (stopped) begin
                assert (tklsb && !tkmsb && txd == K_IDLE)
                    else record_mismatch($sformatf("word %h sent while stopped", txd));
            end
            if (stop_ack) begin
                assert (tklsb && tkmsb && txd == K_EOF)
                    else record_mismatch("stop acknowledge without an end word");
                assert (!stopped) else report_problem("extra stop acknowledge pulse");
                ack_count <= ack_count + 1;
                stopped   <= 1'b1;
            end else if (start) begin
                stopped <= 1'b0;
            end

            if (enable_seen) begin
                assert (enable) else record_mismatch("o_enable dropped after start");
            end
            if (enable) enable_seen <= 1'b1;
            if (inj_count == 0) begin
                assert (err_count == 0) else record_mismatch("error count moved on clean loop");
            end
        end
    end

    task automatic wait_stop_ack();
        int   c;
        logic got;
        got = 1'b0;
        for (c = 0; c < ACK_LIMIT && !got; c++) begin
            @(posedge sys_clk_50);
            got = stop_ack;
        end
        if (!got) report_problem("no stop acknowledge after stop request");
    endtask

    task automatic run_pattern(input tlk_mode_t run_mode, input logic inject, input int run_idx);
        int run_cycles;
        run_cycles = MIN_RUN + int'($urandom % (MAX_RUN - MIN_RUN + 1));
        @(posedge sys_clk_50);
        mode   <= run_mode;
        inj_on <= inject;
        start  <= 1'b1;
        @(posedge sys_clk_50);
        start <= 1'b0;
        repeat (run_cycles) @(posedge sys_clk_50);
        stop <= 1'b1;
        @(posedge sys_clk_50);
        stop <= 1'b0;
        wait_stop_ack();
        repeat (3) @(posedge sys_clk_50);   // counters trail the end word
        assert (ack_count == run_idx + 1) else record_mismatch(
            $sformatf("%0d stop acks after %0d stops", ack_count, run_idx + 1));
        assert (frame_count == tlk_count_t'(eof_seen - inj_count)) else record_mismatch(
            $sformatf("frame count %0d, expected %0d", frame_count, eof_seen - inj_count));
        assert (err_count == tlk_count_t'(inj_count))
            else record_mismatch($sformatf("error count %0d, expected %0d", err_count, inj_count));
        if (inject && inj_count == 0) report_problem("injection run corrupted no word");
        inj_on <= 1'b0;
    endtask

    initial begin
        void'($urandom(78));
        sys_rstn <= 1'b0;
        start    <= 1'b0;
        stop     <= 1'b0;
        mode     <= PAT_INCR;
        inj_on   <= 1'b0;
        repeat (3) @(posedge sys_clk_50);
        sys_rstn <= 1'b1;
        @(posedge sys_clk_50);
        assert (txd == K_IDLE && tklsb && !tkmsb && !enable && !stop_ack
                && frame_count == 0 && err_count == 0)
            else record_mismatch("outputs after reset are not idle");
        for (int m = 0; m < 4; m++) begin
            run_pattern(tlk_mode_t'(m), 1'b0, m);
        end
        run_pattern(PAT_PRBS, 1'b1, 4);
        repeat (4) @(posedge sys_clk_50);
        if (!enable_seen) report_problem("o_enable never rose");
        $display("errors: %0d mismatches, %0d other", mismatch_errs, problem_errs);
        if (mismatch_errs == 0 && problem_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk_50);
        report_problem("watchdog expired before the runs completed");
        $display("errors: %0d mismatches, %0d other", mismatch_errs, problem_errs);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: source/tlk_link_top.sv
`timescale 1ns/10ps

module tlk_link_top #(
    parameter int FRAME_LEN  = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                i_sys_clk_50,
    input  logic                i_sys_rstn,
    input  logic                i_start,
    input  logic                i_stop,
    input  tlk_pkg::tlk_mode_t  i_mode,
    output logic                o_stop_ack,
    output tlk_pkg::tlk_data_t  o_txd,
    output logic                o_tkmsb,
    output logic                o_tklsb,
    output logic                o_enable,
    input  tlk_pkg::tlk_data_t  i_rxd,
    input  logic                i_rkmsb,
    input  logic                i_rklsb,
    output tlk_pkg::tlk_count_t o_frame_count,
    output tlk_pkg::tlk_count_t o_err_count
);
    import tlk_pkg::*;

    tlk_word_t gen_word;
    logic      gen_valid;
    logic      fifo_ready;
    tlk_word_t fifo_word;
    logic      fifo_valid;
    logic      tx_ready;

    tlk_pattern_gen #(
        .FRAME_LEN (FRAME_LEN)
    ) u_gen (
        .i_sys_clk_50 (i_sys_clk_50),
        .i_sys_rstn   (i_sys_rstn),
        .i_start      (i_start),
        .i_stop       (i_stop),
        .i_mode       (i_mode),
        .o_word       (gen_word),
        .o_valid      (gen_valid),
        .i_ready      (fifo_ready)
    );

    tlk_word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .i_sys_clk_50 (i_sys_clk_50),
        .i_sys_rstn   (i_sys_rstn),
        .i_word       (gen_word),
        .i_valid      (gen_valid),
        .o_ready      (fifo_ready),
        .o_word       (fifo_word),
        .o_valid      (fifo_valid),
        .i_ready      (tx_ready)
    );

    tlk_tx_framer u_framer (
        .i_sys_clk_50 (i_sys_clk_50),
        .i_sys_rstn   (i_sys_rstn),
        .i_word       (fifo_word),
        .i_valid      (fifo_valid),
        .o_ready      (tx_ready),
        .o_txd        (o_txd),
        .o_tkmsb      (o_tkmsb),
        .o_tklsb      (o_tklsb),
        .o_enable     (o_enable),
        .o_stop_ack   (o_stop_ack)
    );

    // receive side, fed back from the serializer
    tlk_rx_checker #(
        .FRAME_LEN (FRAME_LEN)
    ) u_checker (
        .i_sys_clk_50  (i_sys_clk_50),
        .i_sys_rstn    (i_sys_rstn),
        .i_rxd         (i_rxd),
        .i_rkmsb       (i_rkmsb),
        .i_rklsb       (i_rklsb),
        .o_frame_count (o_frame_count),
        .o_err_count   (o_err_count)
    );

endmodule

// File: source/tlk_rx_checker.sv
`timescale 1ns/10ps

module tlk_rx_checker #(
    parameter int FRAME_LEN = 8
) (
    input  logic                i_sys_clk_50,
    input  logic                i_sys_rstn,
    input  tlk_pkg::tlk_data_t  i_rxd,
    input  logic                i_rkmsb,
    input  logic                i_rklsb,
    output tlk_pkg::tlk_count_t o_frame_count,
    output tlk_pkg::tlk_count_t o_err_count
);
    import tlk_pkg::*;

    // one spare code above FRAME_LEN so overlong frames stay visible
    localparam int CNT_W = $clog2(FRAME_LEN + 2);
    localparam logic [CNT_W-1:0] LEN_VAL = CNT_W'(FRAME_LEN);

    tlk_data_t        rxd_q;
    logic             rkmsb_q;
    logic             rklsb_q;
    logic             is_sof;
    logic             is_eof;
    logic             is_data;
    logic             in_frame;
    logic             bad_q;        // a mismatch was seen in this frame
    logic             mismatch;
    tlk_mode_t        mode_q;
    tlk_data_t        exp_q;        // expected next data word
    logic [CNT_W-1:0] data_cnt;

    // input register
    always_ff @(posedge i_sys_clk_50) begin
        if (!i_sys_rstn) begin
            rkmsb_q <= 1'b0;
            rklsb_q <= 1'b0;
        end else begin
            rkmsb_q <= i_rkmsb;
            rklsb_q <= i_rklsb;
        end
        rxd_q <= i_rxd;
    end

    assign is_sof   = rklsb_q && !rkmsb_q && (rxd_q[7:0] == K_SOF[7:0]);
    assign is_eof   = rklsb_q && rkmsb_q && (rxd_q == K_EOF);
    assign is_data  = !rklsb_q && !rkmsb_q;   // idle fill words carry a k flag
    assign mismatch = in_frame && is_data && (rxd_q != exp_q);

    always_ff @(posedge i_sys_clk_50) begin
        if (!i_sys_rstn) begin
            in_frame      <= 1'b0;
            bad_q         <= 1'b0;
            data_cnt      <= '0;
            o_frame_count <= '0;
            o_err_count   <= '0;
        end else if (is_sof) begin
            in_frame <= 1'b1;
            bad_q    <= 1'b0;
            data_cnt <= '0;
        end else if (in_frame && is_data) begin
            if (data_cnt != '1) begin
                data_cnt <= data_cnt + 1'b1;
            end
            if (mismatch) begin
                bad_q <= 1'b1;
                if (o_err_count != '1) begin
                    o_err_count <= o_err_count + 1'b1;
                end
            end
        end else if (in_frame && is_eof) begin
            in_frame <= 1'b0;
            if (data_cnt != LEN_VAL) begin
                if (o_err_count != '1) begin
                    o_err_count <= o_err_count + 1'b1;
                end
            end else if (!bad_q && o_frame_count != '1) begin
                o_frame_count <= o_frame_count + 1'b1;
            end
        end
    end

    // expected pattern, stepped from itself so one bad word counts once
    always_ff @(posedge i_sys_clk_50) begin
        if (is_sof) begin
            mode_q <= tlk_mode_t'(rxd_q[10:8]);
            exp_q  <= tlk_first_word(tlk_mode_t'(rxd_q[10:8]));
        end else if (in_frame && is_data) begin
            exp_q <= tlk_next_word(mode_q, exp_q);
        end
    end

endmodule

// File: source/tlk_tx_framer.sv
`timescale 1ns/10ps

module tlk_tx_framer (
    input  logic               i_sys_clk_50,
    input  logic               i_sys_rstn,
    input  tlk_pkg::tlk_word_t i_word,
    input  logic               i_valid,
    output logic               o_ready,
    output tlk_pkg::tlk_data_t o_txd,
    output logic               o_tkmsb,
    output logic               o_tklsb,
    output logic               o_enable,
    output logic               o_stop_ack
);
    import tlk_pkg::*;

    tlk_tx_state_t state;
    logic          final_q;     // current frame closes the run

    // words are only pulled during the data phase
    assign o_ready = (state == TX_DATA);

    always_ff @(posedge i_sys_clk_50) begin
        if (!i_sys_rstn) begin
            state      <= TX_IDLE;
            o_txd      <= K_IDLE;
            o_tkmsb    <= 1'b0;
            o_tklsb    <= 1'b1;
            o_enable   <= 1'b0;
            o_stop_ack <= 1'b0;
            final_q    <= 1'b0;
        end else begin
            o_stop_ack <= 1'b0;

            case (state)
                TX_IDLE: begin
                    o_txd   <= K_IDLE;
                    o_tkmsb <= 1'b0;
                    o_tklsb <= 1'b1;
                    if (i_valid) begin
                        state    <= TX_SOF;
                        o_enable <= 1'b1;   // sticky once traffic begins
                    end
                end

                TX_SOF: begin
                    // head word is held, so its mode is stable here
                    o_txd   <= {5'b00000, i_word.mode, K_SOF[7:0]};
                    o_tkmsb <= 1'b0;
                    o_tklsb <= 1'b1;
                    state   <= TX_DATA;
                end

                TX_DATA: begin
                    if (i_valid) begin
                        o_txd   <= i_word.data;
                        o_tkmsb <= 1'b0;
                        o_tklsb <= 1'b0;
                        if (i_word.last) begin
                            final_q <= i_word.is_final;
                            state   <= TX_EOF;
                        end
                    end else begin
                        // fifo ran dry mid frame, fill with idle
                        o_txd   <= K_IDLE;
                        o_tkmsb <= 1'b0;
                        o_tklsb <= 1'b1;
                    end
                end

                TX_EOF: begin
                    o_txd      <= K_EOF;
                    o_tkmsb    <= 1'b1;
                    o_tklsb    <= 1'b1;
                    o_stop_ack <= final_q;  // lines up with the end word
                    final_q    <= 1'b0;
                    state      <= TX_IDLE;
                end

                default: begin
                    o_txd   <= K_IDLE;
                    o_tkmsb <= 1'b0;
                    o_tklsb <= 1'b1;
                    state   <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

// File: source/tlk_word_fifo.sv
`timescale 1ns/10ps

module tlk_word_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic               i_sys_clk_50,
    input  logic               i_sys_rstn,
    input  tlk_pkg::tlk_word_t i_word,
    input  logic               i_valid,
    output logic               o_ready,
    output tlk_pkg::tlk_word_t o_word,
    output logic               o_valid,
    input  logic               i_ready
);
    import tlk_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    tlk_word_t   mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;    // msb is the wrap bit
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        wr_en;
    logic        rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // write refused while full, even with a read in the same cycle
    assign o_ready = !full;
    assign wr_en   = i_valid && !full;

    assign o_valid = !empty;
    assign rd_en   = i_ready && !empty;
    assign o_word  = mem[rd_ptr[AW-1:0]];   // head word, no read latency

    always_ff @(posedge i_sys_clk_50) begin
        if (!i_sys_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_sys_clk_50) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= i_word;
        end
    end

endmodule

// File: source/tlk_pattern_gen.sv
`timescale 1ns/10ps

module tlk_pattern_gen #(
    parameter int FRAME_LEN = 8
) (
    input  logic               i_sys_clk_50,
    input  logic               i_sys_rstn,
    input  logic               i_start,
    input  logic               i_stop,
    input  tlk_pkg::tlk_mode_t i_mode,
    output tlk_pkg::tlk_word_t o_word,
    output logic               o_valid,
    input  logic               i_ready
);
    import tlk_pkg::*;

    localparam int CNT_W = $clog2(FRAME_LEN + 1);
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(FRAME_LEN - 1);

    tlk_gen_state_t   state;
    tlk_mode_t        mode_q;
    tlk_data_t        data_q;
    logic [CNT_W-1:0] word_idx;     // position inside the frame
    logic             last_word;
    logic             take;

    assign o_valid   = (state != GEN_IDLE);
    assign take      = o_valid && i_ready;
    assign last_word = (word_idx == LAST_IDX);

    always_comb begin
        o_word.data     = data_q;
        o_word.last     = last_word;
        o_word.is_final = (state == GEN_DRAIN);   // only the closing frame
        o_word.mode     = mode_q;
    end

    always_ff @(posedge i_sys_clk_50) begin
        if (!i_sys_rstn) begin
            state    <= GEN_IDLE;
            word_idx <= '0;
        end else begin
            case (state)
                GEN_IDLE: begin
                    if (i_start) begin
                        state <= GEN_RUN;
                    end
                end
                GEN_RUN: begin
                    // start is ignored here, stop is held as pending
                    if (i_stop) begin
                        state <= GEN_DRAIN;
                    end
                end
                GEN_DRAIN: begin
                    if (take && last_word) begin
                        state <= GEN_IDLE;
                    end
                end
                default: state <= GEN_IDLE;
            endcase

            if (take) begin
                word_idx <= last_word ? '0 : word_idx + 1'b1;
            end
        end
    end

    // pattern register, restarts at every frame boundary
    always_ff @(posedge i_sys_clk_50) begin
        if (state == GEN_IDLE && i_start) begin
            mode_q <= i_mode;
            data_q <= tlk_first_word(i_mode);
        end else if (take) begin
            data_q <= last_word ? tlk_first_word(mode_q) : tlk_next_word(mode_q, data_q);
        end
    end

endmodule

// File: source/tlk_pkg.sv
package tlk_pkg;

    // one word on the serializer bus
    typedef logic [15:0] tlk_data_t;

    // frame and error counters
    typedef logic [15:0] tlk_count_t;

    typedef enum logic [2:0] {
        PAT_INCR = 3'd0,    // counting up from zero
        PAT_PRBS = 3'd1,    // lfsr x^16+x^14+x^13+x^11+1
        PAT_ALT  = 3'd2,    // 5555 / aaaa toggle
        PAT_WALK = 3'd3     // walking one
    } tlk_mode_t;

    // generator to framer stream, 21 bits
    typedef struct packed {
        tlk_data_t data;
        logic      last;        // final data word of the frame
        logic      is_final;    // last frame before stop
        tlk_mode_t mode;
    } tlk_word_t;

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_RUN,
        GEN_DRAIN   // stop pending, finishing the frame
    } tlk_gen_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SOF,
        TX_DATA,
        TX_EOF
    } tlk_tx_state_t;

    // control words
    localparam tlk_data_t K_IDLE = 16'hBCC5;   // tklsb set
    localparam tlk_data_t K_SOF  = 16'h00FB;   // high byte gets the mode when sent
    localparam tlk_data_t K_EOF  = 16'hFDFD;   // both k flags set

    function automatic tlk_data_t tlk_first_word(input tlk_mode_t mode);
        case (mode)
            PAT_PRBS: return 16'hACE1;
            PAT_ALT:  return 16'h5555;
            PAT_WALK: return 16'h0001;
            default:  return 16'h0000;
        endcase
    endfunction

    function automatic tlk_data_t tlk_next_word(input tlk_mode_t mode, input tlk_data_t cur);
        tlk_data_t nxt;
        case (mode)
            PAT_PRBS: nxt = {cur[14:0], cur[15] ^ cur[13] ^ cur[12] ^ cur[10]};
            PAT_ALT:  nxt = ~cur;
            PAT_WALK: nxt = {cur[14:0], cur[15]};
            default:  nxt = cur + 16'd1;
        endcase
        return nxt;
    endfunction

endpackage
